// File: design/csa_tree_8.sv
`timescale 1ns/100ps

module csa_tree_8 import simd_mult_pkg::*; (
    input  simd_d_t [TREE_ROWS-1:0] i_rows,
    output simd_d_t [1:0] o_rows // [0] sum, [1] carry
);

// 3:2 compressor across the whole word
function automatic simd_d_t [1:0] csa_3_2(simd_d_t x, simd_d_t y, simd_d_t z);
    simd_d_t [1:0] r;
    r[0].d = x.d ^ y.d ^ z.d; // sum bits
    r[1].d = ((x.d & y.d) | (x.d & z.d) | (y.d & z.d)) << 1; // carry out, msb drops
    return r;
endfunction

simd_d_t [1:0] l1_a, l1_b; // 8 -> 6
simd_d_t [1:0] l2_a, l2_b; // 6 -> 4
simd_d_t [1:0] l3; // 4 -> 3
simd_d_t [1:0] l4; // 3 -> 2

// level 1, two compressors, rows 6 and 7 wait
assign l1_a = csa_3_2(i_rows[0], i_rows[1], i_rows[2]);
assign l1_b = csa_3_2(i_rows[3], i_rows[4], i_rows[5]);

// level 2
assign l2_a = csa_3_2(l1_a[0], l1_a[1], l1_b[0]);
assign l2_b = csa_3_2(l1_b[1], i_rows[6], i_rows[7]);

// level 3, l2_b carry passes through
assign l3 = csa_3_2(l2_a[0], l2_a[1], l2_b[0]);

// level 4
assign l4 = csa_3_2(l3[0], l3[1], l2_b[1]);

assign o_rows = l4;

endmodule

// File: design/mult_ctrl.sv
`timescale 1ns/100ps

module mult_ctrl import simd_mult_pkg::*; (
    input  logic clk,
    input  logic i_reset,
    input  stage_ctrl_t i_stage,
    input  mult_op_t i_op,
    output lane_mode_t o_lane_mode,
    output logic o_signed,
    output logic o_load,
    output logic o_clear,
    output simd_d_t o_corr_q,
    output mult_op_t o_op_q
);

mult_op_t op_norm; // op with unused codes folded to mul
simd_d_t corr; // correction for the current op

// decode front end op
always_comb begin
    op_norm = i_op;
    o_lane_mode = LANE_32;
    corr = CORR_W32;
    case (i_op)
        MULT_OP_MUL,
        MULT_OP_MULH,
        MULT_OP_MULHSU,
        MULT_OP_MULHU: begin
            o_lane_mode = LANE_32; // one 32x32 lane
            corr = CORR_W32;
        end
        MULT_OP_DOT16: begin
            o_lane_mode = LANE_16;
            corr = CORR_DOT16; // bit 31 terms cancel mod 2^32
        end
        MULT_OP_DOT8: begin
            o_lane_mode = LANE_8;
            corr = CORR_DOT8; // bit 15 terms land above the 17 kept bits
        end
        default: begin
            op_norm = MULT_OP_MUL; // codes 6 and 7 behave as mul
            o_lane_mode = LANE_32;
            corr = CORR_W32;
        end
    endcase
end

// mulhu is the one unsigned matrix
assign o_signed = (i_op != MULT_OP_MULHU);

// stage control to load and clear pulses
assign o_clear = i_stage.flush;
assign o_load = i_stage.en & ~i_stage.flush; // flush has priority

// op and corr ride along with the data stage
always_ff @(posedge clk) begin
    if (i_reset || o_clear) begin
        o_op_q <= MULT_OP_MUL;
        o_corr_q <= '0;
    end else if (o_load) begin
        o_op_q <= op_norm;
        o_corr_q <= corr;
    end
end

endmodule

// File: design/mult_result.sv
`timescale 1ns/100ps

module mult_result import simd_mult_pkg::*; (
    input  logic clk,
    input  logic i_reset,
    input  logic i_load,
    input  logic i_clear,
    pp_stage_if.dst stage,
    input  simd_d_t i_corr_q,
    input  mult_op_t i_op_q,
    output simd_t o_p
);

simd_d_t [TREE_ROWS-1:0] rows_q; // first tree outputs, exe/mem boundary
simd_t a_q;
logic b_sign_q;

// stage register, same rule as the control side
always_ff @(posedge clk) begin
    if (i_reset || i_clear) begin
        rows_q <= '0;
        a_q <= '0;
        b_sign_q <= 1'b0;
    end else if (i_load) begin
        rows_q <= stage.tree_rows;
        a_q <= stage.a;
        b_sign_q <= stage.b_sign;
    end
end

// final reduction of the eight registered rows
simd_d_t [1:0] tree_f;
csa_tree_8 csa_tree_8_f_i (
    .i_rows (rows_q),
    .o_rows (tree_f)
);

simd_d_t mul_u; // unsigned matrix sum
simd_d_t mul_s; // corrected, signed sum
simd_t mul_su;

// carry propagate add
assign mul_u.d = tree_f[0].d + tree_f[1].d;
assign mul_s.d = mul_u.d + i_corr_q.d;

// signed x unsigned, add a back in the high word when b was negative
assign mul_su = b_sign_q ? (mul_s.w[1] + a_q) : mul_s.w[1];

// dot products share the signed sum, only matrix and corr differ
simd_t dot16;
simd_t dot8;
assign dot16 = mul_s.w[0]; // low 32 bits of the lane sum
assign dot8 = {{DOT8_PAD{mul_s.d[DOT8_W-1]}}, mul_s.d[DOT8_W-1:0]}; // 17 bit sext

// result select on the registered op
always_comb begin
    case (i_op_q)
        MULT_OP_MUL: o_p = mul_s.w[0];
        MULT_OP_MULH: o_p = mul_s.w[1];
        MULT_OP_MULHSU: o_p = mul_su;
        MULT_OP_MULHU: o_p = mul_u.w[1]; // no correction when unsigned
        MULT_OP_DOT16: o_p = dot16;
        MULT_OP_DOT8: o_p = dot8;
        default: o_p = mul_s.w[0]; // ctrl never registers 6 or 7
    endcase
end

endmodule

// File: design/pp_gen.sv
`timescale 1ns/100ps

module pp_gen import simd_mult_pkg::*; (
    input  lane_mode_t i_lane_mode,
    input  logic i_signed,
    input  simd_t i_a,
    input  simd_t i_b,
    pp_stage_if.src pp,
    output simd_d_t [TREE_ROWS*TREE_COUNT-1:0] o_rows
);

int lane_lg; // log2 of lane size
int lane_last; // lane-local index of the sign bit

// lane size, lanes are powers of two so div and mod become shifts and masks
always_comb begin
    case (i_lane_mode)
        LANE_8: lane_lg = $clog2(ARCH_WIDTH_B);
        LANE_16: lane_lg = $clog2(ARCH_WIDTH_H);
        default: lane_lg = $clog2(ARCH_WIDTH);
    endcase
    lane_last = (1 << lane_lg) - 1;
end

simd_t [ARCH_WIDTH-1:0] pp_bits; // row i is a[i] against all of b

// and matrix, baugh-wooley flips, diagonal tile mask
always_comb begin
    int li;
    int lj;
    logic y;
    logic flip;
    logic keep;
    for (int i = 0; i < ARCH_WIDTH; i++) begin
        for (int j = 0; j < ARCH_WIDTH; j++) begin
            li = i & lane_last; // position inside the lane
            lj = j & lane_last;
            y = i_a[i] & i_b[j];
            // sign row or sign column, xor skips the sign x sign corner
            flip = i_signed && ((li == lane_last) != (lj == lane_last));
            // only tiles on the diagonal pair a lane with itself
            keep = ((i >> lane_lg) == (j >> lane_lg));
            pp_bits[i][j] = keep & (y ^ flip);
        end
    end
end

// align each row into a 64 bit addend
always_comb begin
    simd_d_t row;
    for (int i = 0; i < ARCH_WIDTH; i++) begin
        row.d = {{ARCH_WIDTH{1'b0}}, pp_bits[i]};
        // weight by lane-local index, then pull the lane back to bit 0
        // so packed lanes sum on top of each other
        o_rows[i].d = (row.d << (i & lane_last)) >> ((i >> lane_lg) << lane_lg);
    end
end

// side data for the stage
assign pp.a = i_a;
assign pp.b_sign = i_b[ARCH_WIDTH-1];

endmodule

// File: design/pp_stage_if.sv
`timescale 1ns/100ps

// first level tree outputs plus side data headed for the stage register
interface pp_stage_if import simd_mult_pkg::*; ();

simd_d_t [2*TREE_COUNT-1:0] tree_rows; // sum and carry of each first tree
simd_t a; // operand a, for the mulhsu fixup
logic b_sign; // msb of operand b

// producers, pp_gen plus the trees wired at top
modport src (
    output tree_rows,
    output a,
    output b_sign
);

// consumer is the result stage
modport dst (
    input tree_rows,
    input a,
    input b_sign
);

endinterface

// File: design/simd_mult_pkg.sv
package simd_mult_pkg;

// operand widths
localparam int unsigned ARCH_WIDTH = 32;
localparam int unsigned ARCH_WIDTH_H = ARCH_WIDTH / 2; // half word, dot16 lane
localparam int unsigned ARCH_WIDTH_D = ARCH_WIDTH * 2; // full product
localparam int unsigned ARCH_WIDTH_B = ARCH_WIDTH / 4; // byte, dot8 lane

// dot8 keeps 17 bits, rest is sign pad
localparam int unsigned DOT8_W = ARCH_WIDTH_H + 1;
localparam int unsigned DOT8_PAD = ARCH_WIDTH - DOT8_W;

// reduction shape
localparam int unsigned TREE_ROWS = 8; // rows into one csa tree
localparam int unsigned TREE_COUNT = ARCH_WIDTH / TREE_ROWS; // first level trees

typedef logic [ARCH_WIDTH-1:0] simd_t;

// 64 bit word, flat or as two halves
typedef union packed {
    logic [ARCH_WIDTH_D-1:0] d;
    simd_t [1:0] w; // w[0] low, w[1] high
} simd_d_t;

// bit 2 marks packed ops
typedef enum logic [2:0] {
    MULT_OP_MUL = 3'd0,
    MULT_OP_MULH = 3'd1,
    MULT_OP_MULHSU = 3'd2,
    MULT_OP_MULHU = 3'd3,
    MULT_OP_DOT16 = 3'd4,
    MULT_OP_DOT8 = 3'd5
} mult_op_t;

// lane size of the pp matrix
typedef enum logic [1:0] {
    LANE_32,
    LANE_16,
    LANE_8
} lane_mode_t;

typedef struct packed {
    logic en;
    logic flush; // wins over en
} stage_ctrl_t;

// modified baugh-wooley correction words
localparam simd_d_t CORR_W32 = 64'h8000_0001_0000_0000; // bits 63 and 32
localparam simd_d_t CORR_DOT16 = 64'h0000_0000_0002_0000; // 2x bit 16 per lane pair
localparam simd_d_t CORR_DOT8 = 64'h0000_0000_0000_0400; // 4x bit 8 folded

endpackage

// File: design/simd_mult_top.sv
`timescale 1ns/100ps

module simd_mult_top import simd_mult_pkg::*; (
    input  logic clk,
    input  logic i_reset,
    input  logic i_stage_en,
    input  logic i_stage_flush,
    input  mult_op_t i_op,
    input  simd_t i_a,
    input  simd_t i_b,
    output simd_t o_p
);

lane_mode_t lane_mode;
logic is_signed;
logic load; // stage capture
logic clear; // stage flush
simd_d_t corr_q;
mult_op_t op_q;
simd_d_t [TREE_ROWS*TREE_COUNT-1:0] pp_rows; // aligned partial products

pp_stage_if pp_stage_if_i ();

// decode and registered op state
mult_ctrl mult_ctrl_i (
    .clk (clk),
    .i_reset (i_reset),
    .i_stage ({i_stage_en, i_stage_flush}), // packs as {en, flush}
    .i_op (i_op),
    .o_lane_mode (lane_mode),
    .o_signed (is_signed),
    .o_load (load),
    .o_clear (clear),
    .o_corr_q (corr_q),
    .o_op_q (op_q)
);

pp_gen pp_gen_i (
    .i_lane_mode (lane_mode),
    .i_signed (is_signed),
    .i_a (i_a),
    .i_b (i_b),
    .pp (pp_stage_if_i.src),
    .o_rows (pp_rows)
);

// first level, eight rows per tree, two rows out each
for (genvar t = 0; t < TREE_COUNT; t++) begin : g_tree
    csa_tree_8 csa_tree_8_i (
        .i_rows (pp_rows[t*TREE_ROWS +: TREE_ROWS]),
        .o_rows (pp_stage_if_i.tree_rows[2*t +: 2])
    );
end

// stage register onward
mult_result mult_result_i (
    .clk (clk),
    .i_reset (i_reset),
    .i_load (load),
    .i_clear (clear),
    .stage (pp_stage_if_i.dst),
    .i_corr_q (corr_q),
    .i_op_q (op_q),
    .o_p (o_p)
);

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the simd_mult testbench with verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --top-module simd_mult_tb \
    -f simd_mult.f \
    -o simd_mult_sim

./obj_dir/simd_mult_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^Done: no errors$" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: simd_mult.f
design/simd_mult_pkg.sv
design/pp_stage_if.sv
design/mult_ctrl.sv
design/pp_gen.sv
design/csa_tree_8.sv
design/mult_result.sv
design/simd_mult_top.sv
verification/simd_mult_assertions.sv
verification/simd_mult_tb.sv

// File: verification/simd_mult_assertions.sv
`timescale 1ns/100ps

module simd_mult_assertions import simd_mult_pkg::*; (
    input logic clk,
    input logic i_reset,
    input stage_ctrl_t i_stage,
    input mult_op_t i_op,
    input mult_op_t i_op_q,
    input simd_d_t i_corr_q
);

// enable low and no flush, op state must not move
hold_when_idle: assert property (@(posedge clk)
    !i_reset && !i_stage.en && !i_stage.flush |=> $stable(i_op_q) && $stable(i_corr_q))
    else $error("op state changed while the stage was idle");

// load edge takes the front end op, codes 6 and 7 as mul
load_takes_op: assert property (@(posedge clk)
    !i_reset && i_stage.en && !i_stage.flush |=>
    i_op_q == (($past(i_op) > MULT_OP_DOT8) ? MULT_OP_MUL : $past(i_op)))
    else $error("registered op does not match the loaded op");

// flush edge leaves mul with zero correction
flush_to_mul: assert property (@(posedge clk)
    i_stage.flush |=> (i_op_q == MULT_OP_MUL) && (i_corr_q.d == '0))
    else $error("stage not cleared after flush");

reset_to_mul: assert property (@(posedge clk) i_reset |=> i_op_q == MULT_OP_MUL)
    else $error("registered op is not mul after reset");

endmodule

bind mult_ctrl simd_mult_assertions simd_mult_assertions_i (
    .clk (clk),
    .i_reset (i_reset),
    .i_stage (i_stage),
    .i_op (i_op),
    .i_op_q (o_op_q),
    .i_corr_q (o_corr_q)
);

// File: verification/simd_mult_tb.sv
`timescale 1ns/100ps

module simd_mult_tb import simd_mult_pkg::*; ();

localparam int CLK_PERIOD = 8;
localparam int RESET_CYCLES = 3;
localparam int RAND_COUNT = 200;
localparam int MAX_LINES = 256; // bound on the vector file read loop
localparam int MAX_CYCLES = 1000; // watchdog

logic clk;
logic i_reset;
logic i_stage_en;
logic i_stage_flush;
mult_op_t i_op;
simd_t i_a;
simd_t i_b;
simd_t o_p;

int errors;
logic [31:0] rng_state;
logic pending; // a result is due at the next check
simd_t pending_exp;
string pending_tag;
simd_t model_p; // value o_p should hold right now

simd_mult_top uut (
    .clk (clk),
    .i_reset (i_reset),
    .i_stage_en (i_stage_en),
    .i_stage_flush (i_stage_flush),
    .i_op (i_op),
    .i_a (i_a),
    .i_b (i_b),
    .o_p (o_p)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

// stuck run guard
initial begin
    for (int c = 0; c < MAX_CYCLES; c++) begin
        @(posedge clk);
    end
    $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
    stop_on_error();
end

task automatic stop_on_error();
    errors++;
    $display("Done: errors found");
    $fatal(1, "first error, run stopped");
endtask

task automatic check_result(input simd_t got, input simd_t exp, input string what);
    if (got !== exp) begin
        $display("MISMATCH at %0t ns: %s, o_p %h expected %h", $time, what, got, exp);
        stop_on_error();
    end
endtask

task automatic check_reset(input simd_t got, input string what);
    if (got !== '0) begin
        $display("MISMATCH at %0t ns: %s, o_p %h expected zero", $time, what, got);
        stop_on_error();
    end
endtask

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic simd_t draw_operand();
    rng_state = lcg_next(rng_state);
    return rng_state;
endfunction

// rv32m and packed dot products from wide arithmetic
function automatic simd_t ref_product(input mult_op_t op, input simd_t a, input simd_t b);
    logic signed [63:0] ss;
    logic signed [63:0] su;
    logic [63:0] uu;
    int dot;
    simd_t r;
    ss = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    su = $signed({{32{a[31]}}, a}) * $signed({32'h0, b}); // b zero extended
    uu = {32'h0, a} * {32'h0, b};
    dot = 0;
    case (op)
        MULT_OP_MULH: r = ss[63:32];
        MULT_OP_MULHSU: r = su[63:32];
        MULT_OP_MULHU: r = uu[63:32];
        MULT_OP_DOT16: begin
            for (int k = 0; k < 2; k++)
                dot += int'($signed(a[16*k +: 16])) * int'($signed(b[16*k +: 16]));
            r = dot; // wraps to low 32 bits
        end
        MULT_OP_DOT8: begin
            for (int k = 0; k < 4; k++)
                dot += int'($signed(a[8*k +: 8])) * int'($signed(b[8*k +: 8]));
            r = {{15{dot[16]}}, dot[16:0]}; // keep 17 bits, sign extend
        end
        default: r = ss[31:0];
    endcase
    return r;
endfunction

// drive one line, then check the line before it, one edge later
task automatic apply_vector(input logic en, input logic flush, input mult_op_t op,
                            input simd_t a, input simd_t b, input simd_t exp,
                            input string tag);
    @(posedge clk);
    i_stage_en <= en;
    i_stage_flush <= flush;
    i_op <= op;
    i_a <= a;
    i_b <= b;
    @(negedge clk); // o_p settled from the load edge
    if (pending)
        check_result(o_p, pending_exp, pending_tag);
    pending = 1'b1;
    pending_exp = exp;
    pending_tag = tag;
endtask

task automatic run_vectors();
    int fd;
    int n;
    int idx;
    string line;
    logic en;
    logic flush;
    logic [2:0] op_raw;
    simd_t a;
    simd_t b;
    simd_t exp;
    fd = $fopen("verification/simd_mult_vectors.txt", "r");
    if (fd == 0) begin
        $display("could not open the vector file verification/simd_mult_vectors.txt");
        stop_on_error();
    end
    idx = 0;
    for (int ln = 0; ln < MAX_LINES && !$feof(fd); ln++) begin
        line = "";
        n = $fgets(line, fd);
        n = $sscanf(line, "%h %h %h %h %h %h", en, flush, op_raw, a, b, exp);
        if (n == 6) begin // header and blank lines fall through
            apply_vector(en, flush, mult_op_t'(op_raw), a, b, exp,
                         $sformatf("vector %0d op %0d", idx, op_raw));
            model_p = exp;
            idx++;
        end
    end
    $fclose(fd);
    if (idx == 0) begin
        $display("the vector file held no vector lines");
        stop_on_error();
    end
endtask

task automatic run_random();
    simd_t ra;
    simd_t rb;
    mult_op_t rop;
    logic ren;
    for (int k = 0; k < RAND_COUNT; k++) begin
        ra = draw_operand();
        rb = draw_operand();
        rop = mult_op_t'(3'((draw_operand() >> 16) % 32'd6));
        ren = ((draw_operand() >> 20) % 32'd8) != 0; // hold about one in eight
        if (ren)
            model_p = ref_product(rop, ra, rb);
        apply_vector(ren, 1'b0, rop, ra, rb, model_p, $sformatf("random %0d op %0d", k, rop));
    end
endtask

initial begin
    errors = 0;
    rng_state = 32'h91fb;
    pending = 1'b0;
    pending_exp = '0;
    pending_tag = "";
    model_p = '0;
    i_reset = 1'b1;
    i_stage_en = 1'b0;
    i_stage_flush = 1'b0;
    i_op = MULT_OP_MUL;
    i_a = '0;
    i_b = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    i_reset <= 1'b0;
    @(negedge clk);
    check_reset(o_p, "after reset");
    // enable low, busy inputs must not leak through
    for (int k = 0; k < 4; k++) begin
        @(posedge clk);
        i_op <= MULT_OP_MULH;
        i_a <= draw_operand();
        i_b <= draw_operand();
        @(negedge clk);
        check_reset(o_p, "idle after reset");
    end
    run_vectors();
    run_random();
    // last load, then a held edge that sees new operands
    @(posedge clk);
    i_stage_en <= 1'b0;
    i_a <= draw_operand();
    i_b <= draw_operand();
    @(negedge clk);
    check_result(o_p, pending_exp, pending_tag);
    @(posedge clk);
    @(negedge clk);
    check_result(o_p, model_p, "final hold");
    if (errors == 0) begin
        $display("Done: no errors");
        $finish;
    end else begin
        $display("Done: errors found");
        $fatal(1, "errors seen");
    end
end

endmodule

// File: verification/simd_mult_vectors.txt
# en flush op a b p, all hex, op 0 mul 1 mulh 2 mulhsu 3 mulhu 4 dot16 5 dot8
# p is o_p after the edge that samples the line
1 0 0 00000000 12345678 00000000
1 0 0 00000003 00000007 00000015
1 0 1 00000003 00000007 00000000
1 0 0 ffffffff ffffffff 00000001
1 0 3 ffffffff ffffffff fffffffe
1 0 2 ffffffff ffffffff ffffffff
1 0 1 80000000 80000000 40000000
1 0 2 80000000 80000000 c0000000
1 0 3 80000000 80000000 40000000
1 0 1 80000000 ffffffff 00000000
1 0 2 00000001 ffffffff 00000000
1 0 2 ffffffff 00000002 ffffffff
1 0 1 7fffffff 7fffffff 3fffffff
1 0 0 12345678 00000010 23456780
1 0 4 00030002 00050004 00000017
1 0 4 ffff0002 0003ffff fffffffb
1 0 4 80008000 80008000 80000000
1 0 4 7fff8000 80007fff 80010000
1 0 5 01020304 05060708 00000046
1 0 5 ffffffff 01010101 fffffffc
1 0 5 80808080 80808080 ffff0000
1 0 5 7f7f7f7f 80808080 ffff0200
0 0 0 00000005 00000005 ffff0200
1 1 0 00000002 00000003 00000000
1 0 0 00000002 00000003 00000006
1 0 4 00010001 00010001 00000002
1 0 3 ffffffff 00000002 00000001
1 0 5 02020202 fefefefe fffffff0
1 0 1 ffffffff 00000002 ffffffff
0 1 0 00000000 00000000 00000000
